//--- issueStage.f
rtl/isaPkg.sv
rtl/issuePkg.sv
rtl/ringBufferControl.sv
rtl/hazardCheck.sv
rtl/commitTracker.sv
rtl/wbIssueFrontend.sv
rtl/issueStage.sv
sim/clockGen.sv
sim/issueChecker.sv
sim/issueStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the issue stage testbench with Verilator and runs it.
# Exit status is zero only when the pass message appears in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module issueStageTb -f issueStage.f -o issueStageSim \
	&& ./obj_dir/issueStageSim | tee /dev/stderr | grep -F "Test completed successfully" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- sim/issueStageTb.sv
// Testbench top for the issue stage.
// Sends random instruction writes and commit count reads over Wishbone, then drains.
`timescale 1ns/1ps
`default_nettype none

module issueStageTb
	import issuePkg::*;
();

	localparam int NUM_ENTRY     = 2; // Shallow table so the ring fills and stalls
	localparam int SLOT_WIDTH    = $clog2(NUM_ENTRY);
	localparam int NUM_TRANSFERS = 400;
	localparam int ACK_TIMEOUT   = 200;
	localparam int DRAIN_TIMEOUT = 100;
	localparam int RESET_TIMEOUT = 100;

	logic                  clock;
	logic                  reset;
	logic                  cyc;
	logic                  stb;
	logic                  we;
	logic [1:0]            adr;
	logic [31:0]           datWrite;
	logic [31:0]           datRead;
	logic                  ack;
	logic                  issueValid;
	logic [19:0]           issueInstr;
	logic [SLOT_WIDTH-1:0] issueSlot;
	logic                  commitValid;
	logic [SLOT_WIDTH-1:0] commitSlot;
	hazardKindT            hazardStatus;
	int                    errorCount;
	int                    issueCount;
	int                    liveCount;
	int                    stimErrors;
	int                    writeCount;
	bit                    timedOut;
	integer                seed;

	clockGen clocks (
		.clock(clock),
		.reset(reset)
	);

	issueStage #(
		.NUM_ENTRY(NUM_ENTRY)
	) uut (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWrite(datWrite),
		.datRead(datRead),
		.ack(ack),
		.issueValid(issueValid),
		.issueInstr(issueInstr),
		.issueSlot(issueSlot),
		.commitValid(commitValid),
		.commitSlot(commitSlot),
		.hazardStatus(hazardStatus)
	);

	issueChecker #(
		.NUM_ENTRY(NUM_ENTRY)
	) monitor (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWrite(datWrite),
		.datRead(datRead),
		.ack(ack),
		.issueValid(issueValid),
		.issueInstr(issueInstr),
		.issueSlot(issueSlot),
		.commitValid(commitValid),
		.commitSlot(commitSlot),
		.hazardStatus(hazardStatus),
		.errorCount(errorCount),
		.issueCount(issueCount),
		.liveCount(liveCount)
	);

	// Registers come from indices 0 to 7 so conflicts are common
	function automatic logic [31:0] randomInstrWord();
		logic [31:0] r;
		r = $random(seed);
		return {r[31:20], r[19:18], r[17] | r[5], 2'b00, r[16:14],
			r[13], 2'b00, r[12:10], r[9], 2'b00, r[8:6]};
	endfunction

	// Starts just after a rising edge and returns just after one
	task automatic runTransfer(input logic write, input logic [31:0] word);
		int   waited;
		logic acked;
		waited   = 0;
		acked    = 1'b0;
		cyc      = 1'b1;
		stb      = 1'b1;
		we       = write;
		adr      = write ? ADDR_INSTR : ADDR_COMMIT_COUNT;
		datWrite = word;
		while (!acked && waited < ACK_TIMEOUT) begin
			@(negedge clock);
			acked = ack;
			waited++;
		end
		if (!acked) begin
			$display("No ack within %0d cycles for a %s transfer", ACK_TIMEOUT,
				write ? "write" : "read");
			stimErrors++;
			timedOut = 1'b1;
		end
		@(posedge clock);
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	initial begin
		logic [31:0] draw;
		int          waited;
		seed       = 23;
		cyc        = 1'b0;
		stb        = 1'b0;
		we         = 1'b0;
		adr        = ADDR_INSTR;
		datWrite   = '0;
		stimErrors = 0;
		writeCount = 0;
		timedOut   = 1'b0;

		waited = 0;
		while (reset !== 1'b0 && waited < RESET_TIMEOUT) begin
			@(posedge clock);
			waited++;
		end
		if (reset !== 1'b0) begin
			$display("Reset was never released");
			stimErrors++;
			timedOut = 1'b1;
		end
		#1;

		//////////////////////////////////////////////////
		// Random traffic with about one read in ten
		//////////////////////////////////////////////////

		for (int i = 0; i < NUM_TRANSFERS && !timedOut; i++) begin
			draw = $random(seed);
			if (draw[6:4] == 3'd0) begin
				@(posedge clock); // Idle gap
				#1;
			end
			if (draw % 10 == 0) begin
				runTransfer(1'b0, draw);
			end else begin
				runTransfer(1'b1, randomInstrWord());
				if (!timedOut)
					writeCount++;
			end
		end

		waited = 0;
		while (!timedOut && liveCount != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clock);
			waited++;
		end
		if (!timedOut && liveCount != 0) begin
			$display("%0d instructions were still in flight after the drain", liveCount);
			stimErrors++;
		end
		if (!timedOut && issueCount != writeCount) begin
			$display("%0d issues seen for %0d acknowledged writes", issueCount, writeCount);
			stimErrors++;
		end

		$display("Checker errors: %0d, testbench errors: %0d", errorCount, stimErrors);
		if (errorCount == 0 && stimErrors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/issueChecker.sv
// Testbench monitor for the issue stage.
// Models the in-flight set from issue and commit events and counts mismatches.
`timescale 1ns/1ps
`default_nettype none

module issueChecker
	import issuePkg::*;
#(
	parameter int NUM_ENTRY = 8,
	localparam int SLOT_WIDTH = $clog2(NUM_ENTRY)
)(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  logic [1:0]            adr,
	input  logic [31:0]           datWrite,
	input  logic [31:0]           datRead,
	input  logic                  ack,
	input  logic                  issueValid,
	input  logic [19:0]           issueInstr,
	input  logic [SLOT_WIDTH-1:0] issueSlot,
	input  logic                  commitValid,
	input  logic [SLOT_WIDTH-1:0] commitSlot,
	input  hazardKindT            hazardStatus,
	output int                    errorCount,
	output int                    issueCount,
	output int                    liveCount
);

	logic [19:0]          flightInstr [NUM_ENTRY];
	int                   issueCycle [NUM_ENTRY];
	logic [NUM_ENTRY-1:0] flightValid;
	logic [NUM_ENTRY-1:0] committed; // Leaves the set one cycle after its commit
	int                   cycle;
	int                   commitTotal;
	logic                 holding;
	logic                 reading;
	hazardKindT           expectedStatus;

	function automatic int latencyOf(input logic [1:0] op);
		case (op)
			2'd0:    return 2;
			2'd1:    return 3;
			2'd2:    return 5;
			default: return 8;
		endcase
	endfunction

	// Fields are {valid, index} with the valid flag on top
	function automatic logic fieldsMatch(input logic [5:0] a, input logic [5:0] b);
		return a[5] && b[5] && (a[4:0] == b[4:0]);
	endfunction

	function automatic hazardKindT conflictKind(input logic [19:0] newW, input logic [19:0] oldW);
		if (fieldsMatch(newW[11:6], oldW[17:12]) || fieldsMatch(newW[5:0], oldW[17:12]))
			return hzRaw;
		if (fieldsMatch(newW[17:12], oldW[11:6]) || fieldsMatch(newW[17:12], oldW[5:0]))
			return hzWar;
		if (fieldsMatch(newW[17:12], oldW[17:12]))
			return hzWaw;
		return hzNone;
	endfunction

	function automatic hazardKindT worstConflict(input logic [19:0] w);
		hazardKindT kind;
		logic       anyRaw;
		logic       anyWar;
		logic       anyWaw;
		anyRaw = 1'b0;
		anyWar = 1'b0;
		anyWaw = 1'b0;
		for (int s = 0; s < NUM_ENTRY; s++) begin
			if (flightValid[s]) begin
				kind = conflictKind(w, flightInstr[s]);
				anyRaw = anyRaw | (kind == hzRaw);
				anyWar = anyWar | (kind == hzWar);
				anyWaw = anyWaw | (kind == hzWaw);
			end
		end
		if (anyRaw)
			return hzRaw;
		if (anyWar)
			return hzWar;
		return anyWaw ? hzWaw : hzNone;
	endfunction

	task automatic reportMismatch(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("[ERROR] %s: expected %0h, actual %0h", testName, expected, actual);
		errorCount++;
	endtask

	task automatic reportProblem(input string text);
		$display("Cycle %0d: %s", cycle, text);
		errorCount++;
	endtask

	//////////////////////////////////////////////////
	// Sampled mid-cycle away from the drive edge
	//////////////////////////////////////////////////

	always @(negedge clock) begin
		hazardKindT kind;
		logic       idle;
		logic       instrWrite;
		if (reset) begin
			errorCount     = 0;
			issueCount     = 0;
			liveCount      = 0;
			cycle          = 0;
			commitTotal    = 0;
			flightValid    = '0;
			committed      = '0;
			holding        = 1'b0;
			reading        = 1'b0;
			expectedStatus = hzNone;
		end else begin
			cycle++;
			if (hazardStatus !== expectedStatus)
				reportMismatch("hazard status", 32'(expectedStatus), 32'(hazardStatus));
			if (ack !== ((holding && issueValid) || reading))
				reportMismatch("ack", {31'b0, (holding && issueValid) || reading}, {31'b0, ack});
			if (reading && datRead !== 32'(commitTotal))
				reportMismatch("commit count read", 32'(commitTotal), datRead);

			// Checked against the set of the previous cycle
			if (issueValid) begin
				if (!holding)
					reportProblem("issueValid with no instruction write held");
				if (issueInstr !== datWrite[19:0])
					reportMismatch("issue content", {12'b0, datWrite[19:0]}, {12'b0, issueInstr});
				kind = worstConflict(issueInstr);
				if (kind != hzNone)
					reportProblem($sformatf("instruction %h issued over a %s conflict",
						issueInstr, kind.name()));
			end

			for (int s = 0; s < NUM_ENTRY; s++) begin
				if (committed[s]) begin
					flightValid[s] = 1'b0;
					committed[s]   = 1'b0;
					liveCount--;
				end
			end

			if (issueValid) begin
				// Slots are handed out in ring order from zero
				if (issueSlot !== SLOT_WIDTH'(issueCount % NUM_ENTRY))
					reportMismatch("issue slot", 32'(issueCount % NUM_ENTRY), 32'(issueSlot));
				if (flightValid[issueSlot])
					reportProblem($sformatf("slot %0d reused while still in flight", issueSlot));
				flightValid[issueSlot] = 1'b1;
				committed[issueSlot]   = 1'b0;
				flightInstr[issueSlot] = issueInstr;
				issueCycle[issueSlot]  = cycle;
				issueCount++;
				liveCount++;
				if (liveCount > NUM_ENTRY)
					reportProblem($sformatf("%0d instructions in flight", liveCount));
			end

			if (commitValid) begin
				if (!flightValid[commitSlot] || committed[commitSlot]) begin
					reportProblem($sformatf("commit for slot %0d, which is not in flight",
						commitSlot));
				end else begin
					if (cycle - issueCycle[commitSlot] != latencyOf(flightInstr[commitSlot][19:18]))
						reportMismatch("commit latency",
							32'(latencyOf(flightInstr[commitSlot][19:18])),
							32'(cycle - issueCycle[commitSlot]));
					committed[commitSlot] = 1'b1;
				end
				commitTotal++;
			end

			for (int s = 0; s < NUM_ENTRY; s++) begin
				if (flightValid[s] && !committed[s]
						&& cycle - issueCycle[s] >= latencyOf(flightInstr[s][19:18])) begin
					reportProblem($sformatf("slot %0d missed its commit cycle", s));
					committed[s] = 1'b1;
				end
			end

			// Held instruction is checked against this cycle's set
			expectedStatus = (holding && !issueValid) ? worstConflict(datWrite[19:0]) : hzNone;

			idle       = !holding && !reading;
			instrWrite = cyc && stb && we && (adr == ADDR_INSTR);
			reading    = idle && cyc && stb && !instrWrite;
			holding    = holding ? !issueValid : (idle && instrWrite);
		end
	end

endmodule

`default_nettype wire

//--- sim/clockGen.sv
// Testbench clock and reset source for the issue stage.
// 8 ns clock, reset held high for the first 16 rising edges.
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 16
)(
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0; // Released just after the edge, like all stimulus
	end

endmodule

`default_nettype wire

//--- rtl/issueStage.sv
// Top of the scoreboarded issue stage.
// Joins the Wishbone frontend, hazard check and commit tracker, and sets the table depth.
`timescale 1ns/1ps
`default_nettype none

module issueStage
	import isaPkg::*;
	import issuePkg::*;
#(
	parameter int NUM_ENTRY = 8,
	localparam int SLOT_WIDTH = $clog2(NUM_ENTRY)
)(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [1:0]             adr,
	input  logic [31:0]            datWrite,
	output logic [31:0]            datRead,
	output logic                   ack,
	output logic                   issueValid,
	output logic [INSTR_WIDTH-1:0] issueInstr,
	output logic [SLOT_WIDTH-1:0]  issueSlot,
	output logic                   commitValid,
	output logic [SLOT_WIDTH-1:0]  commitSlot,
	output hazardKindT             hazardStatus
);

	logic                   pending;
	logic [INSTR_WIDTH-1:0] instr;
	logic [MAX_LATENCY-1:0] pendingEnds;
	opcodeT                 issueOpcode;

	assign issueOpcode = opcodeT'(issueInstr[OP_MSB:OP_LSB]);

	wbIssueFrontend frontend (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWrite(datWrite),
		.datRead(datRead),
		.ack(ack),
		.pending(pending),
		.instr(instr),
		.issueValid(issueValid),
		.commitValid(commitValid)
	);

	hazardCheck #(
		.NUM_ENTRY(NUM_ENTRY)
	) hazards (
		.clock(clock),
		.reset(reset),
		.pending(pending),
		.instr(instr),
		.commitValid(commitValid),
		.commitSlot(commitSlot),
		.pendingEnds(pendingEnds),
		.issueValid(issueValid),
		.issueInstr(issueInstr),
		.issueSlot(issueSlot),
		.hazardStatus(hazardStatus)
	);

	commitTracker #(
		.NUM_ENTRY(NUM_ENTRY)
	) tracker (
		.clock(clock),
		.reset(reset),
		.issueValid(issueValid),
		.issueSlot(issueSlot),
		.issueOpcode(issueOpcode),
		.commitValid(commitValid),
		.commitSlot(commitSlot),
		.pendingEnds(pendingEnds)
	);

endmodule

`default_nettype wire

//--- rtl/wbIssueFrontend.sv
// Wishbone classic slave for the issue stage.
// Holds one instruction until it issues, and serves reads of the commit counter.
`timescale 1ns/1ps
`default_nettype none

module wbIssueFrontend
	import isaPkg::*;
	import issuePkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [1:0]             adr,
	input  logic [31:0]            datWrite,
	output logic [31:0]            datRead,
	output logic                   ack,
	output logic                   pending,
	output logic [INSTR_WIDTH-1:0] instr,
	input  logic                   issueValid,
	input  logic                   commitValid
);

	frontStateT state;
	logic [COMMIT_COUNT_WIDTH-1:0] commitCount;
	logic instrWrite;

	assign instrWrite = cyc & stb & we & (adr == ADDR_INSTR);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: begin
					if (cyc && stb)
						state <= instrWrite ? stHold : stAck;
				end
				stHold:  if (issueValid) state <= stIdle;
				stAck:   state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == stIdle && instrWrite)
			instr <= datWrite[INSTR_WIDTH-1:0];
	end

	always_ff @(posedge clock) begin
		if (reset)
			commitCount <= '0;
		else if (commitValid)
			commitCount <= commitCount + 1'b1;
	end

	assign pending = (state == stHold);
	assign ack     = (state == stAck) | (pending & issueValid); // Held ack is the back-pressure
	assign datRead = (state == stAck && adr == ADDR_COMMIT_COUNT) ? 32'(commitCount) : '0;

endmodule

`default_nettype wire

//--- rtl/commitTracker.sv
// Fixed-latency completion model, one down-counter per table slot.
// Reports one commit per cycle and exposes upcoming commit cycles as a mask.
`timescale 1ns/1ps
`default_nettype none

module commitTracker
	import isaPkg::*;
#(
	parameter int NUM_ENTRY = 8,
	localparam int SLOT_WIDTH = $clog2(NUM_ENTRY)
)(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issueValid,
	input  logic [SLOT_WIDTH-1:0]  issueSlot,
	input  opcodeT                 issueOpcode,
	output logic                   commitValid,
	output logic [SLOT_WIDTH-1:0]  commitSlot,
	output logic [MAX_LATENCY-1:0] pendingEnds
);

	logic [LATENCY_WIDTH-1:0] countdown [NUM_ENTRY];

	// Zero means idle, one means commit this cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ENTRY; i++)
				countdown[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_ENTRY; i++) begin
				if (issueValid && issueSlot == SLOT_WIDTH'(i))
					countdown[i] <= opLatency(issueOpcode);
				else if (countdown[i] != '0)
					countdown[i] <= countdown[i] - 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// End mask, bit k set when a slot commits k cycles from now
	//////////////////////////////////////////////////

	always_comb begin
		commitSlot  = '0;
		pendingEnds = '0;
		for (int i = 0; i < NUM_ENTRY; i++) begin
			if (countdown[i] == LATENCY_WIDTH'(1))
				commitSlot = SLOT_WIDTH'(i);
			for (int k = 0; k < MAX_LATENCY; k++) begin
				if (countdown[i] == LATENCY_WIDTH'(k + 1))
					pendingEnds[k] = 1'b1;
			end
		end
	end

	assign commitValid = pendingEnds[0];

endmodule

`default_nettype wire

//--- rtl/hazardCheck.sv
// Scoreboard of issued, uncommitted instructions.
// Checks the held instruction for RAW, WAR and WAW conflicts and issues it when clear.
`timescale 1ns/1ps
`default_nettype none

module hazardCheck
	import isaPkg::*;
	import issuePkg::*;
#(
	parameter int NUM_ENTRY = 8,
	localparam int SLOT_WIDTH = $clog2(NUM_ENTRY)
)(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   pending,
	input  logic [INSTR_WIDTH-1:0] instr,
	input  logic                   commitValid,
	input  logic [SLOT_WIDTH-1:0]  commitSlot,
	input  logic [MAX_LATENCY-1:0] pendingEnds,
	output logic                   issueValid,
	output logic [INSTR_WIDTH-1:0] issueInstr,
	output logic [SLOT_WIDTH-1:0]  issueSlot,
	output hazardKindT             hazardStatus
);

	localparam int END_WIDTH = $clog2(MAX_LATENCY);

	logic [INSTR_WIDTH-1:0]   entryTable [NUM_ENTRY];
	logic [NUM_ENTRY-1:0]     slotBusy;
	logic [NUM_ENTRY-1:0]     slotFree;
	logic [NUM_ENTRY-1:0]     rawHit;
	logic [NUM_ENTRY-1:0]     warHit;
	logic [NUM_ENTRY-1:0]     wawHit;
	logic [SLOT_WIDTH-1:0]    writeSlot;
	logic [SLOT_WIDTH-1:0]    readSlot;
	logic [LATENCY_WIDTH-1:0] endIndex;
	logic                     full;
	logic                     empty;
	logic                     checkActive;
	logic                     endBusy;
	logic                     issueNow;
	logic                     readEnable;
	hazardKindT               hazardKind;

	function automatic logic regMatch(
		input logic                       validA,
		input logic [REG_INDEX_WIDTH-1:0] indexA,
		input logic                       validB,
		input logic [REG_INDEX_WIDTH-1:0] indexB
	);
		return validA & validB & (indexA == indexB);
	endfunction

	//////////////////////////////////////////////////
	// Operand comparisons against every entry
	//////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < NUM_ENTRY; i++) begin
			rawHit[i] = regMatch(instr[SRC1_VALID], instr[SRC1_MSB:SRC1_LSB],
					entryTable[i][DST_VALID], entryTable[i][DST_MSB:DST_LSB])
				| regMatch(instr[SRC2_VALID], instr[SRC2_MSB:SRC2_LSB],
					entryTable[i][DST_VALID], entryTable[i][DST_MSB:DST_LSB]);
			warHit[i] = regMatch(instr[DST_VALID], instr[DST_MSB:DST_LSB],
					entryTable[i][SRC1_VALID], entryTable[i][SRC1_MSB:SRC1_LSB])
				| regMatch(instr[DST_VALID], instr[DST_MSB:DST_LSB],
					entryTable[i][SRC2_VALID], entryTable[i][SRC2_MSB:SRC2_LSB]);
			wawHit[i] = regMatch(instr[DST_VALID], instr[DST_MSB:DST_LSB],
				entryTable[i][DST_VALID], entryTable[i][DST_MSB:DST_LSB]);
		end
	end

	always_comb begin
		if (|rawHit)
			hazardKind = hzRaw;
		else if (|warHit)
			hazardKind = hzWar;
		else if (|wawHit)
			hazardKind = hzWaw;
		else
			hazardKind = hzNone;
	end

	// Commit of a new issue would land endIndex cycles from now
	assign endIndex = opLatency(opcodeT'(instr[OP_MSB:OP_LSB])) + 1'b1;
	assign endBusy  = (endIndex < MAX_LATENCY) ? pendingEnds[endIndex[END_WIDTH-1:0]] : 1'b0;

	assign checkActive = pending & ~issueValid; // Skip the cycle of our own issue
	assign issueNow    = checkActive & (hazardKind == hzNone) & ~full & ~endBusy;

	assign slotFree   = ~slotBusy;
	assign readEnable = ~empty & slotFree[readSlot];

	//////////////////////////////////////////////////
	// Table and issue registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			issueValid   <= 1'b0;
			hazardStatus <= hzNone;
		end else begin
			issueValid   <= issueNow;
			hazardStatus <= checkActive ? hazardKind : hzNone;
		end
	end

	always_ff @(posedge clock) begin
		if (issueNow) begin
			issueInstr <= instr;
			issueSlot  <= writeSlot;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			slotBusy <= '0;
			for (int i = 0; i < NUM_ENTRY; i++)
				entryTable[i] <= '0;
		end else begin
			if (commitValid) begin
				slotBusy[commitSlot]               <= 1'b0;
				entryTable[commitSlot][DST_VALID]  <= 1'b0;
				entryTable[commitSlot][SRC1_VALID] <= 1'b0;
				entryTable[commitSlot][SRC2_VALID] <= 1'b0;
			end
			if (issueNow) begin
				slotBusy[writeSlot]   <= 1'b1;
				entryTable[writeSlot] <= instr;
			end
		end
	end

	ringBufferControl #(
		.NUM_ENTRY(NUM_ENTRY)
	) ringControl (
		.clock(clock),
		.reset(reset),
		.writeEnable(issueNow),
		.readEnable(readEnable),
		.writeSlot(writeSlot),
		.readSlot(readSlot),
		.full(full),
		.empty(empty)
	);

endmodule

`default_nettype wire

//--- rtl/ringBufferControl.sv
// In-order slot allocation for the hazard table.
// Write side hands out slots at issue, read side retires them once freed.
`timescale 1ns/1ps
`default_nettype none

module ringBufferControl #(
	parameter int NUM_ENTRY = 8,
	localparam int SLOT_WIDTH = $clog2(NUM_ENTRY),
	localparam int COUNT_WIDTH = $clog2(NUM_ENTRY + 1)
)(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  writeEnable,
	input  logic                  readEnable,
	output logic [SLOT_WIDTH-1:0] writeSlot,
	output logic [SLOT_WIDTH-1:0] readSlot,
	output logic                  full,
	output logic                  empty
);

	logic [COUNT_WIDTH-1:0] count;

	function automatic logic [SLOT_WIDTH-1:0] nextSlot(input logic [SLOT_WIDTH-1:0] ptr);
		return (ptr == SLOT_WIDTH'(NUM_ENTRY - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			writeSlot <= '0;
			readSlot  <= '0;
			count     <= '0;
		end else begin
			if (writeEnable)
				writeSlot <= nextSlot(writeSlot);
			if (readEnable)
				readSlot <= nextSlot(readSlot);
			case ({writeEnable, readEnable})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	assign full  = (count == COUNT_WIDTH'(NUM_ENTRY));
	assign empty = (count == '0);

endmodule

`default_nettype wire

//--- rtl/issuePkg.sv
// Issue control definitions.
// Frontend states, hazard kinds and the Wishbone word address map.
`default_nettype none

package issuePkg;

	typedef enum logic [1:0] {
		stIdle,
		stHold,
		stAck
	} frontStateT;

	typedef enum logic [1:0] {
		hzNone,
		hzRaw,
		hzWar,
		hzWaw
	} hazardKindT;

	// Word addresses on the 2-bit adr bus
	localparam logic [1:0] ADDR_INSTR        = 2'd0;
	localparam logic [1:0] ADDR_COMMIT_COUNT = 2'd1;

	localparam int COMMIT_COUNT_WIDTH = 16;

endpackage

`default_nettype wire

//--- rtl/isaPkg.sv
// Instruction set definitions for the issue stage.
// Opcodes, register index width, instruction word layout and fixed latencies.
`default_nettype none

package isaPkg;

	typedef enum logic [1:0] {
		opAlu,
		opMul,
		opLoad,
		opDiv
	} opcodeT;

	localparam int REG_INDEX_WIDTH = 5;
	localparam int INSTR_WIDTH     = 20;
	localparam int LATENCY_WIDTH   = 4;
	localparam int MAX_LATENCY     = 8;

	// Word layout, top bit down
	localparam int OP_MSB     = 19;
	localparam int OP_LSB     = 18;
	localparam int DST_VALID  = 17;
	localparam int DST_MSB    = 16;
	localparam int DST_LSB    = 12;
	localparam int SRC1_VALID = 11;
	localparam int SRC1_MSB   = 10;
	localparam int SRC1_LSB   = 6;
	localparam int SRC2_VALID = 5;
	localparam int SRC2_MSB   = 4;
	localparam int SRC2_LSB   = 0;

	function automatic logic [LATENCY_WIDTH-1:0] opLatency(input opcodeT op);
		case (op)
			opAlu:   return 4'd2;
			opMul:   return 4'd3;
			opLoad:  return 4'd5;
			default: return 4'd8; // opDiv
		endcase
	endfunction

endpackage

`default_nettype wire
